// File: hdl/pad_pkg.sv
// Shared pad-port types; the port count is fixed at five and the top nibble of a pad word is unused

package pad_pkg;

	// ==============================
	// Widths with a meaning
	// ==============================

	// Host joystick word, active high
	// [3:0] right left down up, [7:4] I II select run, [11:8] III..VI
	typedef logic [11:0] pad_buttons_t;

	typedef logic [15:0] pad_word_t;     // Console pad word, active low
	typedef logic [3:0]  pad_nibble_t;   // Nibble read back by the console
	typedef logic [7:0]  mouse_delta_t;  // Accumulated mouse axis
	typedef logic [3:0]  pad_opts_t;     // Option register
	typedef logic [2:0]  tap_port_t;     // Multitap port counter

	// ==============================
	// Option register bits
	// ==============================

	localparam int OPT_SWAP       = 0;  // Exchange ports 0 and 1
	localparam int OPT_MULTITAP   = 1;
	localparam int OPT_SIX_BUTTON = 2;
	localparam int OPT_MOUSE      = 3;  // Mouse on port 0

	// ==============================
	// Multitap
	// ==============================

	localparam int NUM_PADS = 5;

	// Returned for ports 5 to 7 of the tap
	localparam pad_word_t PAD_IDLE_WORD = 16'h0FFF;

endpackage

// File: hdl/pad_cfg_regs.sv
// Wishbone classic slave with one option register at address 0; only byte lane 0 writes it
`timescale 1ns/100ps

module pad_cfg_regs (
	input  logic                clk_sys,
	input  logic                rst_n,

	// Wishbone classic slave
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [3:0]          wb_adr,
	input  logic [31:0]         wb_dat_w,
	input  logic [3:0]          wb_sel,
	output logic                wb_ack,
	output logic [31:0]         wb_dat_r,

	output pad_pkg::pad_opts_t  opts
);
	import pad_pkg::*;

	logic req;      // New request this cycle
	logic adr_hit;  // Option register selected

	// Ack is held off while high so a held strobe is not answered twice
	assign req     = wb_cyc & wb_stb & ~wb_ack;
	assign adr_hit = (wb_adr == 4'd0);

	// ==============================
	// Handshake and option register
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			opts   <= '0;
		end else begin
			wb_ack <= req;  // One cycle after the request

			if (req && wb_we && adr_hit && wb_sel[0]) begin
				opts <= wb_dat_w[$bits(pad_opts_t)-1:0];
			end
		end
	end

	// ==============================
	// Readback
	// ==============================

	// Data is valid with ack
	always_ff @(posedge clk_sys) begin
		if (req && !wb_we) begin
			if (adr_hit) begin
				wb_dat_r <= 32'(opts);  // Zero-extended
			end else begin
				wb_dat_r <= '0;  // Unmapped
			end
		end
	end

endmodule

// File: hdl/pad_mapper.sv
// Combinational host-to-console mapping; mouse mode replaces port 0 only, after the swap
`timescale 1ns/100ps

module pad_mapper (
	input  pad_pkg::pad_opts_t                         opts,

	// Host joystick words, active high
	input  pad_pkg::pad_buttons_t                      joy_0,
	input  pad_pkg::pad_buttons_t                      joy_1,
	input  pad_pkg::pad_buttons_t                      joy_2,
	input  pad_pkg::pad_buttons_t                      joy_3,
	input  pad_pkg::pad_buttons_t                      joy_4,

	// Mouse side
	input  logic [1:0]                                 mouse_btn,
	input  pad_pkg::pad_nibble_t                       mouse_nibble,

	// One active-low word per multitap port
	output pad_pkg::pad_word_t [pad_pkg::NUM_PADS-1:0] pad_words
);
	import pad_pkg::*;

	pad_buttons_t host [NUM_PADS];  // Host words after swap
	logic [7:0]   mouse_byte;

	// Console layout, high to low:
	// unused nibble, III..VI, left down right up, run select II I
	function automatic pad_word_t to_pad_word(input pad_buttons_t b);
		pad_word_t w;
		w = ~{4'hF, b[11:8], b[1], b[2], b[0], b[3], b[7:4]};
		return w;
	endfunction

	// ==============================
	// Port swap
	// ==============================

	always_comb begin
		if (opts[OPT_SWAP]) begin
			host[0] = joy_1;
			host[1] = joy_0;
		end else begin
			host[0] = joy_0;
			host[1] = joy_1;
		end
		host[2] = joy_2;
		host[3] = joy_3;
		host[4] = joy_4;
	end

	// ==============================
	// Mouse byte
	// ==============================

	// High nibble is the sequenced motion nibble
	// Low nibble carries run and select of port 0 plus both mouse buttons
	assign mouse_byte = {mouse_nibble, ~{host[0][7:6], mouse_btn[0], mouse_btn[1]}};

	// ==============================
	// Pad words
	// ==============================

	always_comb begin
		for (int i = 0; i < NUM_PADS; i++) begin
			pad_words[i] = to_pad_word(host[i]);
		end

		// Same byte in both halves, so select picks nothing extra
		if (opts[OPT_MOUSE]) begin
			pad_words[0] = {mouse_byte, mouse_byte};
		end
	end

endmodule

// File: hdl/mouse_tracker.sv
// Mouse nibble sequencer on port 0; watches clear only, pending motion is dropped while disabled
`timescale 1ns/100ps

module mouse_tracker #(
	parameter int MOUSE_TIMEOUT_BITS = 15  // Inactivity counter width
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  mouse_en,
	input  logic [1:0]            port_ctl,      // Bit 0 select, bit 1 clear
	input  pad_pkg::mouse_delta_t mouse_x,
	input  pad_pkg::mouse_delta_t mouse_y,
	input  logic                  mouse_strobe,  // One-cycle host update
	output pad_pkg::pad_nibble_t  mouse_nibble
);
	import pad_pkg::*;

	logic                          clr_d;    // Clear delayed by one cycle
	logic                          clr_rise;
	logic [MOUSE_TIMEOUT_BITS-1:0] idle_cnt; // Cycles with clear low
	logic [1:0]                    seq_cnt;  // Nibble sequence
	mouse_delta_t                  pend_x;
	mouse_delta_t                  pend_y;
	mouse_delta_t                  pub_x;    // Values being read out
	mouse_delta_t                  pub_y;

	assign clr_rise = port_ctl[1] & ~clr_d;

	// ==============================
	// Sequence and timeout
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clr_d    <= 1'b0;
			idle_cnt <= '0;
			seq_cnt  <= 2'd3;
			pend_x   <= '0;
			pend_y   <= '0;
			pub_x    <= '0;
			pub_y    <= '0;
		end else begin
			clr_d <= port_ctl[1];

			if (port_ctl[1]) begin
				idle_cnt <= '0;
			end else if (~&idle_cnt) begin
				idle_cnt <= idle_cnt + 1'b1;  // Saturates
			end

			// Host stopped polling so restart at x high
			if (&idle_cnt) begin
				seq_cnt <= 2'd3;
			end

			if (clr_rise) begin
				seq_cnt <= seq_cnt + 2'd1;
				if (&seq_cnt) begin  // Start of a new packet
					pub_x  <= pend_x;
					pub_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			// Later assignments win over the publish clear
			if (!mouse_en) begin
				pend_x <= '0;
				pend_y <= '0;
			end else if (mouse_strobe) begin
				pend_x <= 8'd0 - mouse_x;  // Console x axis is reversed
				pend_y <= mouse_y;
			end
		end
	end

	// ==============================
	// Outgoing nibble
	// ==============================

	always_comb begin
		case (seq_cnt)
			2'd0: mouse_nibble = pub_x[7:4];
			2'd1: mouse_nibble = pub_x[3:0];
			2'd2: mouse_nibble = pub_y[7:4];
			default: mouse_nibble = pub_y[3:0];
		endcase
	end

endmodule

// File: hdl/tap_scanner.sv
// Port scanner and output latch; the tap counter wraps at 8 and ports past 4 read as idle
`timescale 1ns/100ps

module tap_scanner (
	input  logic                                       clk_sys,
	input  logic                                       rst_n,
	input  logic                                       multitap_en,
	input  logic                                       six_button_en,
	input  logic [1:0]                                 port_ctl,  // Bit 0 select, bit 1 clear
	input  pad_pkg::pad_word_t [pad_pkg::NUM_PADS-1:0] pad_words,
	output pad_pkg::pad_nibble_t                       port_data
);
	import pad_pkg::*;

	logic [1:0]  ctl_d;     // Port lines, one cycle late
	logic        sel_rise;
	logic        clr_rise;
	tap_port_t   tap_port;  // Current multitap port
	logic        bank;      // Six-button upper bank
	pad_word_t   cur_word;
	logic [3:0]  nib_base;  // Bit offset of the selected nibble
	pad_nibble_t nibble;

	assign sel_rise = port_ctl[0] & ~ctl_d[0];
	assign clr_rise = port_ctl[1] & ~ctl_d[1];

	// ==============================
	// Nibble selection
	// ==============================

	always_comb begin
		if (tap_port < tap_port_t'(NUM_PADS)) begin
			cur_word = pad_words[tap_port];
		end else begin
			cur_word = PAD_IDLE_WORD;  // Empty tap slot
		end
	end

	// Nibble number is 2*bank + select
	assign nib_base = {bank, port_ctl[0], 2'b00};
	assign nibble   = cur_word[nib_base +: 4];

	// ==============================
	// Port counter and bank
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ctl_d    <= 2'b00;
			tap_port <= '0;
			bank     <= 1'b0;
		end else begin
			ctl_d <= port_ctl;

			if (port_ctl[1]) begin
				tap_port <= '0;  // Clear restarts the scan
			end else if (sel_rise && multitap_en) begin
				tap_port <= tap_port + 3'd1;
			end

			if (!six_button_en) begin
				bank <= 1'b0;
			end else if (clr_rise) begin
				bank <= ~bank;  // Alternate on every clear pulse
			end
		end
	end

	// ==============================
	// Output latch
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			port_data <= '0;
		end else if (port_ctl[1]) begin
			port_data <= '0;  // All lines low during clear
		end else begin
			port_data <= nibble;
		end
	end

endmodule

// File: hdl/pad_port_top.sv
// Standalone pad port; options come only from the Wishbone register and reset to all off
`timescale 1ns/100ps

module pad_port_top #(
	parameter int MOUSE_TIMEOUT_BITS = 15  // Mouse inactivity counter width
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,

	// Wishbone classic slave
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [3:0]            wb_adr,
	input  logic [31:0]           wb_dat_w,
	input  logic [3:0]            wb_sel,
	output logic                  wb_ack,
	output logic [31:0]           wb_dat_r,

	// Host inputs
	input  pad_pkg::pad_buttons_t joy_0,
	input  pad_pkg::pad_buttons_t joy_1,
	input  pad_pkg::pad_buttons_t joy_2,
	input  pad_pkg::pad_buttons_t joy_3,
	input  pad_pkg::pad_buttons_t joy_4,
	input  pad_pkg::mouse_delta_t mouse_x,
	input  pad_pkg::mouse_delta_t mouse_y,
	input  logic [1:0]            mouse_btn,
	input  logic                  mouse_strobe,

	// Console port
	input  logic [1:0]            port_ctl,
	output pad_pkg::pad_nibble_t  port_data
);
	import pad_pkg::*;

	pad_opts_t                  opts;
	pad_nibble_t                mouse_nibble;
	pad_word_t [NUM_PADS-1:0]   pad_words;

	pad_cfg_regs u_cfg (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_ack   (wb_ack),
		.wb_dat_r (wb_dat_r),
		.opts     (opts)
	);

	pad_mapper u_mapper (
		.opts         (opts),
		.joy_0        (joy_0),
		.joy_1        (joy_1),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.mouse_btn    (mouse_btn),
		.mouse_nibble (mouse_nibble),
		.pad_words    (pad_words)
	);

	mouse_tracker #(
		.MOUSE_TIMEOUT_BITS (MOUSE_TIMEOUT_BITS)
	) u_mouse (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.mouse_en     (opts[OPT_MOUSE]),
		.port_ctl     (port_ctl),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.mouse_nibble (mouse_nibble)
	);

	tap_scanner u_scanner (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.multitap_en   (opts[OPT_MULTITAP]),
		.six_button_en (opts[OPT_SIX_BUTTON]),
		.port_ctl      (port_ctl),
		.pad_words     (pad_words),
		.port_data     (port_data)
	);

endmodule

// File: testbench/tb_pad_port.sv
// Runs testbench/pad_testdata.txt from the project root; mouse timeout width is cut to 6 bits
`timescale 1ns/100ps

module tb_pad_port;
	import pad_pkg::*;

	localparam int ACK_LIMIT = 20;  // Cycles allowed for a Wishbone ack

	logic         clk_sys;
	logic         rst_n;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic [3:0]   wb_adr;
	logic [31:0]  wb_dat_w;
	logic [3:0]   wb_sel;
	logic         wb_ack;
	logic [31:0]  wb_dat_r;
	pad_buttons_t joy [NUM_PADS];  // Host words driven into the DUT
	mouse_delta_t mouse_x;
	mouse_delta_t mouse_y;
	logic [1:0]   mouse_btn;
	logic         mouse_strobe;
	logic [1:0]   port_ctl;
	pad_nibble_t  port_data;

	pad_opts_t    opts_model;     // Options as last written
	pad_nibble_t  mouse_nib_exp;  // Last mouse nibble checked
	int           errors;
	int           test_errors;
	int           checks;
	int           tests;
	logic         timed_out;

	pad_port_top #(
		.MOUSE_TIMEOUT_BITS (6)
	) dut0 (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_sel       (wb_sel),
		.wb_ack       (wb_ack),
		.wb_dat_r     (wb_dat_r),
		.joy_0        (joy[0]),
		.joy_1        (joy[1]),
		.joy_2        (joy[2]),
		.joy_3        (joy[3]),
		.joy_4        (joy[4]),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_btn    (mouse_btn),
		.mouse_strobe (mouse_strobe),
		.port_ctl     (port_ctl),
		.port_data    (port_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;  // 10 ns
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] data,
			input logic [3:0] sel, output logic [31:0] rdata);
		int n;
		@(negedge clk_sys);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		wb_sel   = sel;
		@(negedge clk_sys);
		n = 1;
		while (!wb_ack && n < ACK_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!wb_ack) begin
			$display("Wishbone ack did not arrive within %0d cycles", ACK_LIMIT);
			timed_out = 1'b1;
		end else begin
			check_value("ack latency in cycles", n, 1);
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk_sys);
		check_value("ack still high a cycle later", wb_ack, 0);
	endtask

	// Inverted console layout from the top nibble down to run select II I
	function automatic pad_word_t console_word(input pad_buttons_t b);
		logic [3:0]  dpad;
		logic [15:0] v;
		dpad = {b[1], b[2], b[0], b[3]};
		v    = 16'hF000 | (16'(b[11:8]) << 8) | (16'(dpad) << 4) | 16'(b[7:4]);
		return ~v;
	endfunction

	function automatic pad_nibble_t pad_nibble(input int port, input int nib);
		pad_buttons_t h0;
		pad_buttons_t h1;
		pad_word_t    w;
		logic [3:0]   low;
		h0 = opts_model[0] ? joy[1] : joy[0];  // Swap
		h1 = opts_model[0] ? joy[0] : joy[1];
		if (port >= NUM_PADS) begin
			w = 16'h0FFF;  // Empty tap slot
		end else if (port == 0 && opts_model[3]) begin
			low = ~{h0[7], h0[6], mouse_btn[0], mouse_btn[1]};
			w   = {mouse_nib_exp, low, mouse_nib_exp, low};
		end else if (port == 0) begin
			w = console_word(h0);
		end else if (port == 1) begin
			w = console_word(h1);
		end else begin
			w = console_word(joy[port]);
		end
		return w[4*nib +: 4];
	endfunction

	function automatic pad_nibble_t mouse_nibble(input int k);
		logic [7:0] nx;
		nx = ~mouse_x + 8'd1;  // X axis is negated
		case (k)
			0:       return nx[7:4];
			1:       return nx[3:0];
			2:       return mouse_y[7:4];
			default: return mouse_y[3:0];
		endcase
	endfunction

	// ==============================
	// One data line
	// ==============================

	task automatic run_line(input logic [8*96-1:0] line);
		logic [8*8-1:0]  tag;
		logic [8*8-1:0]  kind;
		logic [8*16-1:0] name;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     c;
		logic [31:0]     rd;
		int              r;
		r = $sscanf(line, "%s", tag);
		if (tag == "W") begin
			r = $sscanf(line, "%s %h %h %h", tag, a, b, c);
			wb_access(1'b1, a[3:0], b, c[3:0], rd);
			if (a[3:0] == 4'd0 && c[0]) begin
				opts_model = b[3:0];
			end
		end else if (tag == "R") begin
			r = $sscanf(line, "%s %h %h", tag, a, b);
			wb_access(1'b0, a[3:0], 32'd0, 4'hF, rd);
			check_value($sformatf("read of address %0h", a), rd, b);
		end else if (tag == "H") begin
			@(negedge clk_sys);
			for (int i = 0; i < NUM_PADS; i++) begin
				joy[i] = 12'($urandom);
			end
		end else if (tag == "M") begin
			r = $sscanf(line, "%s %h %h %h", tag, a, b, c);
			@(negedge clk_sys);
			mouse_x      = a[7:0];
			mouse_y      = b[7:0];
			mouse_btn    = c[1:0];
			mouse_strobe = 1'b1;
			@(negedge clk_sys);
			mouse_strobe = 1'b0;
		end else if (tag == "C") begin
			r = $sscanf(line, "%s %d", tag, a);
			wait_cycles(a);
		end else if (tag == "P") begin
			r = $sscanf(line, "%s %h %s %h %h", tag, c, kind, a, b);
			@(negedge clk_sys);
			port_ctl = c[1:0];
			wait_cycles(4);
			if (kind == "K") begin
				check_value($sformatf("port %0d nibble %0d", a, b), port_data,
					pad_nibble(a, b));
			end else if (kind == "X") begin
				mouse_nib_exp = mouse_nibble(a);
				check_value($sformatf("mouse nibble %0d", a), port_data, mouse_nib_exp);
			end else begin
				check_value($sformatf("port_data with port_ctl %b", c[1:0]), port_data, a);
			end
		end else if (tag == "T") begin
			r = $sscanf(line, "%s %s", tag, name);
			tests++;
			if (test_errors == 0) begin
				$display("Test %0s: ok", name);
			end else begin
				$display("Test %0s: %0d errors", name, test_errors);
			end
			test_errors = 0;
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		logic [8*96-1:0] line;
		logic [8*8-1:0]  tag;
		int              fd;
		int              r;
		rst_n = 1'b0;
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w, wb_sel} = '0;
		for (int i = 0; i < NUM_PADS; i++) begin
			joy[i] = '0;
		end
		{mouse_x, mouse_y, mouse_btn, mouse_strobe, port_ctl} = '0;
		{opts_model, mouse_nib_exp, timed_out} = '0;
		{errors, test_errors, checks, tests} = '0;
		r = $urandom(33834);  // Seeded once
		wait_cycles(10);
		check_value("port_data in reset", port_data, 0);
		check_value("wb_ack in reset", wb_ack, 0);
		rst_n = 1'b1;
		wait_cycles(2);

		fd = $fopen("testbench/pad_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/pad_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = '0;
				tag  = '0;
				r    = $fgets(line, fd);
				r    = $sscanf(line, "%s", tag);
				if (r > 0 && tag != "#") begin
					run_line(line);
				end
			end
			$fclose(fd);
		end

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/pad_testdata.txt
# op W adr data sel | R adr expect | H random host words | M x y btn | C cycles | T name
# op P ctl kind a b: kind N expects a, K port a nibble b, X mouse nibble a; hex except C
R 0 0
W 0 5 1
R 0 5
R 3 0
W 0 3 0
R 0 5
W 0 0 1
T regs
H
P 1 K 0 1
P 0 K 0 0
P 1 K 0 1
P 2 N 0 0
T single
W 0 2 1
P 2 N 0 0
P 0 K 0 0
P 1 K 1 1
P 0 K 1 0
P 1 K 2 1
P 0 K 2 0
P 1 K 3 1
P 0 K 3 0
P 1 K 4 1
P 0 K 4 0
P 1 N F 0
T multitap
W 0 3 1
P 2 N 0 0
P 0 K 0 0
P 1 K 1 1
T swap
W 0 4 1
P 2 N 0 0
P 0 K 0 2
P 1 K 0 3
P 2 N 0 0
P 0 K 0 0
T six_button
W 0 8 1
C 70
M 13 5A 1
P 2 N 0 0
P 1 X 0 0
P 0 K 0 0
P 2 N 0 0
P 1 X 1 0
P 2 N 0 0
P 1 X 2 0
P 2 N 0 0
P 1 X 3 0
T mouse_read
M 02 47 2
P 2 N 0 0
P 1 X 0 0
C 70
P 1 X 3 0
M 31 C4 0
P 2 N 0 0
P 1 X 0 0
T mouse_timeout

// File: build.f
hdl/pad_pkg.sv
hdl/pad_cfg_regs.sv
hdl/pad_mapper.sv
hdl/mouse_tracker.sv
hdl/tap_scanner.sv
hdl/pad_port_top.sv
testbench/tb_pad_port.sv

// File: Bender.yml
package:
  name: pad_port

sources:
  - files:
      - hdl/pad_pkg.sv
      - hdl/pad_cfg_regs.sv
      - hdl/pad_mapper.sv
      - hdl/mouse_tracker.sv
      - hdl/tap_scanner.sv
      - hdl/pad_port_top.sv
  - target: simulation
    files:
      - testbench/tb_pad_port.sv
